// File: mbox_consts.svh
// ****************************************
// mailbox constants
// sizes and register map of the mailbox
// ****************************************
`ifndef MBOX_CONSTS_SVH
`define MBOX_CONSTS_SVH

// word and request widths
`define MBOX_DATA_W 32
`define MBOX_ADDR_W 16

// the SRAM holds 256 words, so a word index needs 8 bits
`define MBOX_DEPTH 256
`define MBOX_PTR_W 8

// byte offset bits inside the register window
`define MBOX_OFS_W 10
// address bits above bit 9 select the register window at 0x0400
`define MBOX_CSR_BASE 6'h01

// register byte offsets within the window
`define MBOX_LOCK_OFS    10'h000
`define MBOX_USER_OFS    10'h004
`define MBOX_CMD_OFS     10'h008
`define MBOX_DLEN_OFS    10'h00C
`define MBOX_DATAIN_OFS  10'h010
`define MBOX_DATAOUT_OFS 10'h014
`define MBOX_EXECUTE_OFS 10'h018
`define MBOX_STATUS_OFS  10'h01C

`endif

// File: mbox_csr.sv
// ****************************************
// mailbox register block
// offset decode, mailbox registers, owner-gated writes
// and combinational read data
// ****************************************
`timescale 1ns/1ps
`include "mbox_consts.svh"

module mbox_csr (
    input  logic                 clk,
    input  logic                 rst_b,
    input  logic                 req_dv,
    input  logic                 req_write,
    input  logic                 req_soc,
    input  mbox_pkg::mbox_user_t req_user,
    input  mbox_pkg::mbox_addr_t req_addr,
    input  mbox_pkg::mbox_data_t req_wdata,
    output mbox_pkg::mbox_data_t csr_rdata,
    output logic                 mbox_error,
    mbox_hwif.csr                hw
);
    import mbox_pkg::*;

    logic [`MBOX_OFS_W-1:0] ofs;
    logic       win_hit;
    logic       rd_req;
    logic       wr_req;
    logic       sel_lock, sel_user, sel_cmd, sel_dlen;
    logic       sel_datain, sel_dataout, sel_execute, sel_status;
    logic       ofs_mapped;
    logic       execute_wr;

    logic       lock_q;
    logic       execute_q;
    mbox_user_t user_q;
    logic       soc_owner_q;
    mbox_data_t cmd_q;
    mbox_data_t dlen_q;
    mbox_data_t dataout_q;

    // the upper address bits pick the window and the low bits the register
    assign ofs     = req_addr[`MBOX_OFS_W-1:0];
    assign win_hit = req_addr[`MBOX_ADDR_W-1:`MBOX_OFS_W] == `MBOX_CSR_BASE;
    assign rd_req  = req_dv & win_hit & ~req_write;
    assign wr_req  = req_dv & win_hit & req_write;

    assign sel_lock    = ofs == `MBOX_LOCK_OFS;
    assign sel_user    = ofs == `MBOX_USER_OFS;
    assign sel_cmd     = ofs == `MBOX_CMD_OFS;
    assign sel_dlen    = ofs == `MBOX_DLEN_OFS;
    assign sel_datain  = ofs == `MBOX_DATAIN_OFS;
    assign sel_dataout = ofs == `MBOX_DATAOUT_OFS;
    assign sel_execute = ofs == `MBOX_EXECUTE_OFS;
    assign sel_status  = ofs == `MBOX_STATUS_OFS;

    assign ofs_mapped = sel_lock | sel_user | sel_cmd | sel_dlen |
                        sel_datain | sel_dataout | sel_execute | sel_status;

    // anything in the window that hits no register is an error, read or write
    assign mbox_error = req_dv & win_hit & ~ofs_mapped;

    // reading the lock is what acquires it, so the read itself is the event
    assign hw.lock_rd          = rd_req & sel_lock;
    assign hw.cmd_wr           = wr_req & sel_cmd & hw.valid_user;
    assign hw.dlen_wr          = wr_req & sel_dlen & hw.valid_user;
    assign hw.datain_wr        = wr_req & sel_datain & hw.valid_user;
    assign hw.dataout_rd       = rd_req & sel_dataout;
    assign hw.dataout_rd_owned = rd_req & sel_dataout & hw.valid_user;
    assign execute_wr          = wr_req & sel_execute & hw.valid_user;

    assign hw.lock_value    = lock_q;
    assign hw.execute_value = execute_q;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            lock_q    <= 1'b0;
            execute_q <= 1'b0;
        end else begin
            // release wins over a new grant, though both never come together
            if (hw.lock_clr) begin
                lock_q <= 1'b0;
            end else if (hw.lock_set) begin
                lock_q <= 1'b1;
            end
            if (execute_wr) begin
                execute_q <= req_wdata[0];
            end
        end
    end

    // requester identity is recorded at the moment the lock is granted
    always_ff @(posedge clk) begin
        if (hw.lock_set) begin
            user_q      <= req_user;
            soc_owner_q <= req_soc;
        end
        if (hw.cmd_wr) begin
            cmd_q <= req_wdata;
        end
        if (hw.dlen_wr) begin
            dlen_q <= req_wdata;
        end
        if (hw.dataout_we) begin
            dataout_q <= hw.dataout_next;
        end
    end

    // read mux, datain reads back as zero
    always_comb begin
        csr_rdata = '0;
        if (sel_lock) begin
            csr_rdata = mbox_data_t'(lock_q);
        end else if (sel_user) begin
            csr_rdata = mbox_data_t'(user_q);
        end else if (sel_cmd) begin
            csr_rdata = cmd_q;
        end else if (sel_dlen) begin
            csr_rdata = dlen_q;
        end else if (sel_dataout) begin
            csr_rdata = dataout_q;
        end else if (sel_execute) begin
            csr_rdata = mbox_data_t'(execute_q);
        end else if (sel_status) begin
            // state in the low bits, bit 8 tells whether the soc owns the lock
            csr_rdata[2:0] = hw.state;
            csr_rdata[8]   = soc_owner_q;
        end
    end

endmodule

// File: mbox_ctrl.sv
// ****************************************
// mailbox controller
// protocol FSM, ownership check, SRAM pointers,
// direct SRAM access and dataout refresh
// ****************************************
`timescale 1ns/1ps
`include "mbox_consts.svh"

module mbox_ctrl (
    input  logic                 clk,
    input  logic                 rst_b,
    input  logic                 dir_req_dv,
    input  logic                 req_write,
    input  logic                 req_soc,
    input  mbox_pkg::mbox_user_t req_user,
    input  mbox_pkg::mbox_addr_t req_addr,
    input  mbox_pkg::mbox_data_t req_wdata,
    input  mbox_pkg::mbox_data_t csr_rdata,
    output mbox_pkg::mbox_data_t rdata,
    output logic                 req_hold,
    output logic                 uc_mbox_data_avail,
    output logic                 soc_mbox_data_avail,
    mbox_hwif.ctrl               hw,
    mbox_sram_if.ctrl            sram
);
    import mbox_pkg::*;

    mbox_fsm_state_e state_q;
    mbox_fsm_state_e state_d;

    logic       arc_lock, arc_cmd, arc_dlen, arc_exec, arc_done;
    logic       in_data, in_exec;
    logic       soc_has_lock;
    mbox_user_t lock_user;

    mbox_ptr_t  wrptr, rdptr;
    mbox_ptr_t  dir_ptr;
    logic       datain_owned;
    logic       inc_rdptr, inc_rdptr_f, inc_rdptr_ff;
    logic       update_dataout;

    logic       dir_req_q;
    logic       dir_rd_f;
    logic       sram_we;

    assign in_data = state_q == MBOX_RDY_FOR_DATA;
    assign in_exec = (state_q == MBOX_EXECUTE_UC) | (state_q == MBOX_EXECUTE_SOC);

    // a lock read that finds the lock free takes it
    assign arc_lock = (state_q == MBOX_IDLE) & hw.lock_rd & ~hw.lock_value;
    assign arc_cmd  = (state_q == MBOX_RDY_FOR_CMD) & hw.cmd_wr;
    assign arc_dlen = (state_q == MBOX_RDY_FOR_DLEN) & hw.dlen_wr;
    assign arc_exec = in_data & hw.execute_value;
    // clearing execute ends the transfer and frees the lock
    assign arc_done = in_exec & ~hw.execute_value;

    always_comb begin
        state_d = state_q;
        case (state_q)
            MBOX_IDLE: begin
                if (arc_lock) begin
                    state_d = MBOX_RDY_FOR_CMD;
                end
            end
            MBOX_RDY_FOR_CMD: begin
                if (arc_cmd) begin
                    state_d = MBOX_RDY_FOR_DLEN;
                end
            end
            MBOX_RDY_FOR_DLEN: begin
                if (arc_dlen) begin
                    state_d = MBOX_RDY_FOR_DATA;
                end
            end
            MBOX_RDY_FOR_DATA: begin
                // the message goes to the side that did not take the lock
                if (arc_exec) begin
                    state_d = soc_has_lock ? MBOX_EXECUTE_UC : MBOX_EXECUTE_SOC;
                end
            end
            MBOX_EXECUTE_UC, MBOX_EXECUTE_SOC: begin
                if (arc_done) begin
                    state_d = MBOX_IDLE;
                end
            end
            default: begin
                state_d = MBOX_IDLE;
            end
        endcase
    end

    assign uc_mbox_data_avail  = state_q == MBOX_EXECUTE_UC;
    assign soc_mbox_data_avail = state_q == MBOX_EXECUTE_SOC;

    // the uc owns by side alone, the soc also has to match the tag it locked with
    assign hw.valid_user = hw.lock_value &
                           ((~soc_has_lock & ~req_soc) |
                            (soc_has_lock & req_soc & (req_user == lock_user)));
    assign hw.lock_set   = arc_lock;
    assign hw.lock_clr   = arc_done;
    assign hw.state      = state_q;

    // datain only reaches the SRAM while the message is being filled
    assign datain_owned = in_data & hw.datain_wr;
    // the receiver drains without an ownership check
    assign inc_rdptr = (in_data & hw.dataout_rd_owned) | (in_exec & hw.dataout_rd);

    // a datain write at the read pointer goes straight into dataout
    assign update_dataout = datain_owned & (wrptr == rdptr);

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state_q      <= MBOX_IDLE;
            soc_has_lock <= 1'b0;
            wrptr        <= '0;
            rdptr        <= '0;
            inc_rdptr_f  <= 1'b0;
            inc_rdptr_ff <= 1'b0;
            dir_rd_f     <= 1'b0;
        end else begin
            state_q <= state_d;
            if (arc_lock) begin
                soc_has_lock <= req_soc;
            end
            if (arc_done) begin
                wrptr <= '0;
            end else if (datain_owned) begin
                wrptr <= wrptr + 1'b1;
            end
            if (arc_done) begin
                rdptr <= '0;
            end else if (inc_rdptr) begin
                rdptr <= rdptr + 1'b1;
            end
            // read the new pointer one cycle on, load dataout the cycle after
            inc_rdptr_f  <= inc_rdptr;
            inc_rdptr_ff <= inc_rdptr_f;
            // marks the data phase of a direct read
            dir_rd_f <= dir_req_q & ~req_write;
        end
    end

    always_ff @(posedge clk) begin
        if (arc_lock) begin
            lock_user <= req_user;
        end
    end

    // the second cycle of a direct read is its data phase, not a new request
    assign dir_req_q = dir_req_dv & ~dir_rd_f;
    assign req_hold  = dir_req_q & ~req_write;
    assign dir_ptr   = req_addr[`MBOX_PTR_W+1:2];

    assign sram_we = (dir_req_q & req_write) | datain_owned;

    always_comb begin
        sram.cs    = dir_req_q | sram_we | inc_rdptr_f;
        sram.we    = sram_we;
        sram.wdata = req_wdata;
        if (dir_req_q) begin
            sram.addr = dir_ptr;
        end else if (sram_we) begin
            sram.addr = wrptr;
        end else begin
            sram.addr = rdptr;
        end
    end

    assign rdata = dir_rd_f ? sram.rdata : csr_rdata;

    assign hw.dataout_we   = update_dataout | inc_rdptr_ff;
    assign hw.dataout_next = update_dataout ? req_wdata : sram.rdata;

endmodule

// File: mbox_hwif.sv
// ****************************************
// mailbox register hardware interface
// register events toward the controller and updates back
// ****************************************
`timescale 1ns/1ps

interface mbox_hwif;
    import mbox_pkg::*;

    // register block to controller
    logic lock_value;
    logic lock_rd;
    // these three are already qualified by ownership
    logic cmd_wr;
    logic dlen_wr;
    logic datain_wr;
    logic dataout_rd;
    logic dataout_rd_owned;
    logic execute_value;

    // controller to register block
    logic            valid_user;
    logic            lock_set;
    logic            lock_clr;
    logic            dataout_we;
    mbox_data_t      dataout_next;
    mbox_fsm_state_e state;

    modport csr (
        output lock_value, lock_rd, cmd_wr, dlen_wr, datain_wr,
        output dataout_rd, dataout_rd_owned, execute_value,
        input  valid_user, lock_set, lock_clr, dataout_we, dataout_next, state
    );

    modport ctrl (
        input  lock_value, lock_rd, cmd_wr, dlen_wr, datain_wr,
        input  dataout_rd, dataout_rd_owned, execute_value,
        output valid_user, lock_set, lock_clr, dataout_we, dataout_next, state
    );

endinterface

// File: mbox_pkg.sv
// ****************************************
// mailbox types
// vector typedefs and the protocol state encoding
// ****************************************
`include "mbox_consts.svh"

package mbox_pkg;

    // one data word as seen on the request and the SRAM
    typedef logic [`MBOX_DATA_W-1:0] mbox_data_t;

    // byte address carried with a request
    typedef logic [`MBOX_ADDR_W-1:0] mbox_addr_t;

    // word index into the SRAM
    typedef logic [`MBOX_PTR_W-1:0] mbox_ptr_t;

    // user tag of the requester, compared while the soc holds the lock
    typedef logic [7:0] mbox_user_t;

    // protocol states of the mailbox
    // the value is shown to software through the status register
    typedef enum logic [2:0] {
        MBOX_IDLE         = 3'd0,
        MBOX_RDY_FOR_CMD  = 3'd1,
        MBOX_RDY_FOR_DLEN = 3'd2,
        MBOX_RDY_FOR_DATA = 3'd3,
        MBOX_EXECUTE_UC   = 3'd4,
        MBOX_EXECUTE_SOC  = 3'd5
    } mbox_fsm_state_e;

endpackage

// File: mbox_properties.sv
// ****************************************
// mailbox controller assertions
// direct-read data phase, SRAM port sharing and data-available
// ****************************************
`timescale 1ns/1ps

module mbox_properties (
    input logic clk,
    input logic rst_b,
    input logic req_hold,
    input logic dir_req_dv,
    input logic req_write,
    input logic inc_rdptr_f,
    input logic dir_req_q,
    input logic lock_value,
    input logic uc_avail,
    input logic soc_avail
);

    // the wait cycle of a direct read is followed by its data cycle
    // and the requester must still present a read strobe there
    a_hold_then_data: assert property (@(posedge clk) disable iff (!rst_b)
        req_hold |=> dir_req_dv && !req_write)
        else $error("direct read strobe dropped before its data cycle");

    // the dataout refresh read and a direct access share the SRAM port
    a_no_port_collision: assert property (@(posedge clk) disable iff (!rst_b)
        !(inc_rdptr_f && dir_req_q))
        else $error("dataout refresh collided with a direct access");

    // a receiver only sees data while the sender still holds the lock
    a_avail_locked: assert property (@(posedge clk) disable iff (!rst_b)
        (uc_avail || soc_avail) |-> lock_value)
        else $error("data-available level is high while the lock is free");

endmodule

bind mbox_ctrl mbox_properties u_props (
    .clk         (clk),
    .rst_b       (rst_b),
    .req_hold    (req_hold),
    .dir_req_dv  (dir_req_dv),
    .req_write   (req_write),
    .inc_rdptr_f (inc_rdptr_f),
    .dir_req_q   (dir_req_q),
    .lock_value  (hw.lock_value),
    .uc_avail    (uc_mbox_data_avail),
    .soc_avail   (soc_mbox_data_avail)
);

// File: mbox_sram.sv
// ****************************************
// mailbox SRAM
// single port, synchronous write and one-cycle read
// ****************************************
`timescale 1ns/1ps
`include "mbox_consts.svh"

module mbox_sram (
    input  logic       clk,
    mbox_sram_if.memory sram
);
    import mbox_pkg::*;

    // storage for the message words
    mbox_data_t mem [`MBOX_DEPTH];

    // write and read share the port, we picks which one happens
    always_ff @(posedge clk) begin
        if (sram.cs && sram.we) begin
            mem[sram.addr] <= sram.wdata;
        end
    end

    // read word is registered and then held until the next read
    always_ff @(posedge clk) begin
        if (sram.cs && !sram.we) begin
            sram.rdata <= mem[sram.addr];
        end
    end

endmodule

// File: mbox_sram_if.sv
// ****************************************
// mailbox SRAM port
// request and response between controller and memory
// ****************************************
`timescale 1ns/1ps

interface mbox_sram_if;
    import mbox_pkg::*;

    // request side, driven by the controller
    logic       cs;
    logic       we;
    mbox_ptr_t  addr;
    mbox_data_t wdata;

    // read word, valid the cycle after a read request
    mbox_data_t rdata;

    modport ctrl (
        output cs, we, addr, wdata,
        input  rdata
    );

    modport memory (
        input  cs, we, addr, wdata,
        output rdata
    );

endinterface

// File: mbox_top.sv
// ****************************************
// mailbox top level
// register block, controller and SRAM
// ****************************************
`timescale 1ns/1ps

module mbox_top (
    input  logic                 clk,
    input  logic                 rst_b,
    input  logic                 req_dv,
    input  logic                 dir_req_dv,
    input  logic                 req_write,
    input  logic                 req_soc,
    input  mbox_pkg::mbox_user_t req_user,
    input  mbox_pkg::mbox_addr_t req_addr,
    input  mbox_pkg::mbox_data_t req_wdata,
    output logic                 req_hold,
    output mbox_pkg::mbox_data_t rdata,
    output logic                 mbox_error,
    output logic                 uc_mbox_data_avail,
    output logic                 soc_mbox_data_avail
);
    import mbox_pkg::*;

    // register read data, muxed with direct read data in the controller
    mbox_data_t csr_rdata;

    mbox_hwif    hwif ();
    mbox_sram_if sram_if ();

    mbox_csr u_csr (
        .clk        (clk),
        .rst_b      (rst_b),
        .req_dv     (req_dv),
        .req_write  (req_write),
        .req_soc    (req_soc),
        .req_user   (req_user),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .csr_rdata  (csr_rdata),
        .mbox_error (mbox_error),
        .hw         (hwif.csr)
    );

    mbox_ctrl u_ctrl (
        .clk                 (clk),
        .rst_b               (rst_b),
        .dir_req_dv          (dir_req_dv),
        .req_write           (req_write),
        .req_soc             (req_soc),
        .req_user            (req_user),
        .req_addr            (req_addr),
        .req_wdata           (req_wdata),
        .csr_rdata           (csr_rdata),
        .rdata               (rdata),
        .req_hold            (req_hold),
        .uc_mbox_data_avail  (uc_mbox_data_avail),
        .soc_mbox_data_avail (soc_mbox_data_avail),
        .hw                  (hwif.ctrl),
        .sram                (sram_if.ctrl)
    );

    mbox_sram u_sram (
        .clk  (clk),
        .sram (sram_if.memory)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_mbox -o sim_tb_mbox
out=$(./obj_dir/sim_tb_mbox)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1

// File: src.f
+incdir+.
mbox_pkg.sv
mbox_sram_if.sv
mbox_hwif.sv
mbox_csr.sv
mbox_ctrl.sv
mbox_sram.sv
mbox_top.sv
mbox_properties.sv
tb_mbox.sv

// File: tb_mbox.sv
// ****************************************
// mailbox testbench
// lock, message transfer in both directions,
// ownership, direct SRAM access and errors
// ****************************************
`timescale 1ns/1ps
`include "mbox_consts.svh"

module tb_mbox;
    import mbox_pkg::*;

    // the whole run needs well under 1000 cycles, so this leaves plenty of margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic       clk;
    logic       rst_b;
    logic       req_dv;
    logic       dir_req_dv;
    logic       req_write;
    logic       req_soc;
    mbox_user_t req_user;
    mbox_addr_t req_addr;
    mbox_data_t req_wdata;
    logic       req_hold;
    mbox_data_t rdata;
    logic       mbox_error;
    logic       uc_mbox_data_avail;
    logic       soc_mbox_data_avail;

    int errors;
    int cycles;

    // reference model of the mailbox
    logic            m_lock;
    logic            m_soc_owner;
    mbox_user_t      m_user;
    logic            m_exec;
    mbox_fsm_state_e m_state;
    mbox_data_t      m_msg[$];
    int              m_rd_idx;
    mbox_data_t      m_mem[`MBOX_DEPTH];

    mbox_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // expected register read data from the model
    function automatic mbox_data_t ref_rdata(input logic [9:0] ofs);
        mbox_data_t r;
        r = '0;
        case (ofs)
            `MBOX_LOCK_OFS: r[0] = m_lock;
            `MBOX_DATAOUT_OFS: r = m_msg[m_rd_idx];
            `MBOX_STATUS_OFS: begin
                r[2:0] = m_state;
                r[8]   = m_soc_owner;
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic is_mapped(input logic [9:0] ofs);
        return (ofs <= 10'h01C) && (ofs[1:0] == 2'b00);
    endfunction

    function automatic logic is_owner(input logic soc, input mbox_user_t user);
        return m_lock && (m_soc_owner ? (soc && user == m_user) : !soc);
    endfunction

    task automatic check_data(input string name, input mbox_data_t got, input mbox_data_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // one register request, sampled in its own cycle
    task automatic csr_access(input logic wr, input logic soc, input mbox_user_t user,
                              input logic [9:0] ofs, input mbox_data_t wdata,
                              output mbox_data_t rd, output logic err);
        @(negedge clk);
        req_dv    = 1'b1;
        req_write = wr;
        req_soc   = soc;
        req_user  = user;
        req_addr  = {`MBOX_CSR_BASE, ofs};
        req_wdata = wdata;
        #2;
        rd  = rdata;
        err = mbox_error;
        @(negedge clk);
        req_dv = 1'b0;
    endtask

    task automatic reg_read(input logic soc, input mbox_user_t user, input logic [9:0] ofs);
        mbox_data_t exp;
        mbox_data_t got;
        logic err;
        exp = ref_rdata(ofs);
        csr_access(1'b0, soc, user, ofs, '0, got, err);
        check_data($sformatf("rdata at offset 0x%h", ofs), got, exp);
        check_level("mbox_error", err, !is_mapped(ofs));
        // a free lock is taken by whoever reads it
        if (ofs == `MBOX_LOCK_OFS && !m_lock) begin
            m_lock      = 1'b1;
            m_soc_owner = soc;
            m_user      = user;
            m_state     = MBOX_RDY_FOR_CMD;
        end
        if (ofs == `MBOX_DATAOUT_OFS && (m_state == MBOX_EXECUTE_UC ||
            m_state == MBOX_EXECUTE_SOC)) begin
            m_rd_idx++;
        end
    endtask

    task automatic reg_write(input logic soc, input mbox_user_t user, input logic [9:0] ofs,
                             input mbox_data_t data);
        mbox_data_t got;
        logic err;
        csr_access(1'b1, soc, user, ofs, data, got, err);
        check_level("mbox_error", err, !is_mapped(ofs));
        if (is_owner(soc, user)) begin
            if (ofs == `MBOX_CMD_OFS && m_state == MBOX_RDY_FOR_CMD) begin
                m_state = MBOX_RDY_FOR_DLEN;
            end else if (ofs == `MBOX_DLEN_OFS && m_state == MBOX_RDY_FOR_DLEN) begin
                m_state = MBOX_RDY_FOR_DATA;
            end else if (ofs == `MBOX_DATAIN_OFS && m_state == MBOX_RDY_FOR_DATA) begin
                m_msg.push_back(data);
            end else if (ofs == `MBOX_EXECUTE_OFS) begin
                m_exec = data[0];
            end
        end
        // execute hands the message to the side that did not lock
        if (m_state == MBOX_RDY_FOR_DATA && m_exec) begin
            m_state = m_soc_owner ? MBOX_EXECUTE_UC : MBOX_EXECUTE_SOC;
        end else if ((m_state == MBOX_EXECUTE_UC || m_state == MBOX_EXECUTE_SOC) && !m_exec) begin
            m_state  = MBOX_IDLE;
            m_lock   = 1'b0;
            m_rd_idx = 0;
            m_msg.delete();
        end
    endtask

    task automatic check_avail();
        idle(2);
        check_level("uc_mbox_data_avail", uc_mbox_data_avail, m_state == MBOX_EXECUTE_UC);
        check_level("soc_mbox_data_avail", soc_mbox_data_avail, m_state == MBOX_EXECUTE_SOC);
    endtask

    // run an empty message through so the owner gives the lock back
    task automatic release_lock(input logic soc, input mbox_user_t user);
        reg_write(soc, user, `MBOX_CMD_OFS, 32'h1);
        reg_write(soc, user, `MBOX_DLEN_OFS, 32'h0);
        reg_write(soc, user, `MBOX_EXECUTE_OFS, 32'h1);
        check_avail();
        reg_write(soc, user, `MBOX_EXECUTE_OFS, 32'h0);
        check_avail();
    endtask

    task automatic drain(input logic soc, input int n);
        repeat (n) begin
            reg_read(soc, 8'h00, `MBOX_DATAOUT_OFS);
            idle(3);
        end
    endtask

    task automatic dir_write(input mbox_ptr_t idx, input mbox_data_t data);
        @(negedge clk);
        dir_req_dv = 1'b1;
        req_write  = 1'b1;
        req_addr   = {6'h00, idx, 2'b00};
        req_wdata  = data;
        m_mem[idx] = data;
        @(negedge clk);
        dir_req_dv = 1'b0;
    endtask

    // the strobe stays high for the wait cycle and the data cycle
    task automatic dir_read(input mbox_ptr_t idx);
        @(negedge clk);
        dir_req_dv = 1'b1;
        req_write  = 1'b0;
        req_addr   = {6'h00, idx, 2'b00};
        #2;
        check_level("req_hold", req_hold, 1'b1);
        @(negedge clk);
        #2;
        check_level("req_hold", req_hold, 1'b0);
        check_data("rdata", rdata, m_mem[idx]);
        @(negedge clk);
        dir_req_dv = 1'b0;
    endtask

    initial begin
        mbox_user_t tag_a;
        mbox_data_t w;
        void'($urandom(32'h744a));
        errors      = 0;
        cycles      = 0;
        rst_b       = 1'b0;
        req_dv      = 1'b0;
        dir_req_dv  = 1'b0;
        req_write   = 1'b0;
        req_soc     = 1'b0;
        req_user    = '0;
        req_addr    = '0;
        req_wdata   = '0;
        m_lock      = 1'b0;
        m_soc_owner = 1'b0;
        m_user      = '0;
        m_exec      = 1'b0;
        m_state     = MBOX_IDLE;
        m_rd_idx    = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_b = 1'b1;
        check_avail();
        check_level("req_hold", req_hold, 1'b0);

        // lock is taken by the first read and freed by execute
        reg_read(1'b0, 8'h00, `MBOX_LOCK_OFS);
        reg_read(1'b0, 8'h00, `MBOX_LOCK_OFS);
        release_lock(1'b0, 8'h00);
        reg_read(1'b0, 8'h00, `MBOX_LOCK_OFS);
        release_lock(1'b0, 8'h00);

        // uc sends eight words to the soc
        reg_read(1'b0, 8'h00, `MBOX_LOCK_OFS);
        reg_write(1'b0, 8'h00, `MBOX_CMD_OFS, $urandom);
        reg_write(1'b0, 8'h00, `MBOX_DLEN_OFS, 32'd32);
        repeat (8) reg_write(1'b0, 8'h00, `MBOX_DATAIN_OFS, $urandom);
        reg_read(1'b0, 8'h00, `MBOX_STATUS_OFS);
        reg_write(1'b0, 8'h00, `MBOX_EXECUTE_OFS, 32'h1);
        check_avail();
        drain(1'b1, 8);
        reg_write(1'b0, 8'h00, `MBOX_EXECUTE_OFS, 32'h0);
        check_avail();

        // soc sends to the uc, writes from other tags and the uc are dropped
        tag_a = mbox_user_t'($urandom);
        reg_read(1'b1, tag_a, `MBOX_LOCK_OFS);
        reg_write(1'b1, tag_a, `MBOX_CMD_OFS, $urandom);
        reg_write(1'b1, tag_a, `MBOX_DLEN_OFS, 32'd16);
        repeat (4) begin
            w = $urandom;
            reg_write(1'b1, tag_a ^ 8'h5a, `MBOX_DATAIN_OFS, $urandom);
            reg_write(1'b0, tag_a, `MBOX_DATAIN_OFS, $urandom);
            reg_write(1'b1, tag_a, `MBOX_DATAIN_OFS, w);
        end
        reg_read(1'b1, tag_a, `MBOX_STATUS_OFS);
        reg_write(1'b1, tag_a, `MBOX_EXECUTE_OFS, 32'h1);
        check_avail();
        drain(1'b0, 4);
        reg_write(1'b1, tag_a, `MBOX_EXECUTE_OFS, 32'h0);
        check_avail();

        // direct SRAM writes and read-back
        for (int i = 0; i < 8; i++) begin
            dir_write(mbox_ptr_t'(8'h40 + i * 3), $urandom);
        end
        for (int i = 0; i < 8; i++) begin
            dir_read(mbox_ptr_t'(8'h40 + i * 3));
        end

        // an unmapped offset in the window is an error either way
        reg_read(1'b0, 8'h00, 10'h020);
        reg_write(1'b0, 8'h00, 10'h020, $urandom);

        idle(2);
        $display("checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
